/* source/gpio_pkg.sv */
package gpio_pkg;

  // Wishbone data path
  localparam int DATA_W = 32;
  localparam int SEL_W  = 4;    // Byte lane selects

  // Word offset field sits at address bits 4..2
  localparam int OFS_W = 3;

  // Control register bits
  localparam int CTRL_INTE_BIT = 0;  // Global interrupt enable
  localparam int CTRL_INTS_BIT = 1;  // Sticky interrupt status

  // Defaults picked up by the top level
  localparam int DEF_GPIO_W = 32;
  localparam int DEF_ADDR_W = 8;

  // Register map in words
  typedef enum logic [OFS_W-1:0] {
    REG_IN    = 3'd0,  // Synchronized pad inputs, read only
    REG_OUT   = 3'd1,
    REG_OE    = 3'd2,
    REG_INTE  = 3'd3,
    REG_PTRIG = 3'd4,  // 1 selects rising edge
    REG_AUX   = 3'd5,
    REG_CTRL  = 3'd6,
    REG_INTS  = 3'd7
  } gpio_reg_e;

endpackage

/* source/gpio_wb_slave.sv */
`timescale 1ns/10ps

module gpio_wb_slave
  import gpio_pkg::*;
#(
  parameter int ADDR_W = DEF_ADDR_W
) (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic [DATA_W-1:0] rd_data_i,  // Combinational read mux
  output logic              reg_wr_o,
  output gpio_reg_e         reg_sel_o,
  output logic              ack_o,
  output logic              err_o,
  output logic [DATA_W-1:0] dat_o
);

  logic              req;
  logic              idle;      // No termination on the bus this cycle
  logic              addr_ok;
  logic              start;
  logic [ADDR_W:0]   adr_ext;

  assign req  = cyc_i & stb_i;
  assign idle = ~ack_o & ~err_o;

  // Extra zero on top keeps the upper field non-empty when ADDR_W is 5
  assign adr_ext = {1'b0, adr_i};

  // Full decode, upper bits clear and word aligned
  assign addr_ok = (adr_ext[ADDR_W:OFS_W+2] == '0) && (adr_i[1:0] == 2'b00);

  // Every 3-bit offset maps to a register
  assign reg_sel_o = gpio_reg_e'(adr_i[OFS_W+1:2]);

  // Held writes repeat each cycle, same value each time
  assign reg_wr_o = req & we_i & addr_ok;

  assign start = req & idle;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= start & addr_ok;
      err_o <= start & ~addr_ok;   // Bad address never acks
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      dat_o <= '0;
    end else if (start && addr_ok && !we_i) begin
      dat_o <= rd_data_i;
    end
  end

endmodule

/* source/gpio_regs.sv */
`timescale 1ns/10ps

module gpio_regs
  import gpio_pkg::*;
#(
  parameter int GPIO_W = DEF_GPIO_W
) (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic              reg_wr_i,
  input  gpio_reg_e         reg_sel_i,
  input  logic [DATA_W-1:0] wb_dat_i,
  input  logic [SEL_W-1:0]  wb_sel_i,
  input  logic [GPIO_W-1:0] in_value_i,    // Input register
  input  logic [GPIO_W-1:0] ints_value_i,  // Interrupt status
  input  logic              irq_pending_i,
  input  logic [GPIO_W-1:0] aux_i,
  output logic [DATA_W-1:0] rd_data_o,
  output logic [GPIO_W-1:0] ptrig_o,
  output logic [GPIO_W-1:0] inte_o,
  output logic              ctrl_inte_o,
  output logic [GPIO_W-1:0] ext_pad_o,
  output logic [GPIO_W-1:0] ext_padoe_o
);

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] inte_q;
  logic [GPIO_W-1:0] ptrig_q;
  logic [GPIO_W-1:0] aux_q;
  logic [1:0]        ctrl_q;

  // Merge write data into the selected byte lanes only
  function automatic logic [GPIO_W-1:0] lane_merge(
    input logic [GPIO_W-1:0] cur,
    input logic [DATA_W-1:0] wdat,
    input logic [SEL_W-1:0]  sel
  );
    logic [GPIO_W-1:0] res;
    int                i;
    res = cur;
    for (i = 0; i < GPIO_W; i++) begin
      if (sel[i/8]) begin
        res[i] = wdat[i];
      end
    end
    return res;
  endfunction

  // Pin-wide registers
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      inte_q  <= '0;
      ptrig_q <= '0;
      aux_q   <= '0;
    end else if (reg_wr_i) begin
      case (reg_sel_i)
        REG_OUT:   out_q   <= lane_merge(out_q, wb_dat_i, wb_sel_i);
        REG_OE:    oe_q    <= lane_merge(oe_q, wb_dat_i, wb_sel_i);
        REG_INTE:  inte_q  <= lane_merge(inte_q, wb_dat_i, wb_sel_i);
        REG_PTRIG: ptrig_q <= lane_merge(ptrig_q, wb_dat_i, wb_sel_i);
        REG_AUX:   aux_q   <= lane_merge(aux_q, wb_dat_i, wb_sel_i);
        default: ;  // IN is read only and CTRL and INTS have their own blocks
      endcase
    end
  end

  // Control register
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ctrl_q <= 2'b00;
    end else if (reg_wr_i && reg_sel_i == REG_CTRL) begin
      ctrl_q <= wb_dat_i[1:0];
    end else if (ctrl_q[CTRL_INTE_BIT]) begin
      // Sticky until software clears it
      ctrl_q[CTRL_INTS_BIT] <= ctrl_q[CTRL_INTS_BIT] | irq_pending_i;
    end
  end

  // Read mux zero-extends every register to the bus width
  always_comb begin
    rd_data_o = '0;
    case (reg_sel_i)
      REG_IN:    rd_data_o[GPIO_W-1:0] = in_value_i;
      REG_OUT:   rd_data_o[GPIO_W-1:0] = out_q;
      REG_OE:    rd_data_o[GPIO_W-1:0] = oe_q;
      REG_INTE:  rd_data_o[GPIO_W-1:0] = inte_q;
      REG_PTRIG: rd_data_o[GPIO_W-1:0] = ptrig_q;
      REG_AUX:   rd_data_o[GPIO_W-1:0] = aux_q;
      REG_CTRL:  rd_data_o[1:0]        = ctrl_q;
      REG_INTS:  rd_data_o[GPIO_W-1:0] = ints_value_i;
    endcase
  end

  assign ptrig_o     = ptrig_q;
  assign inte_o      = inte_q;
  assign ctrl_inte_o = ctrl_q[CTRL_INTE_BIT];

  // Aux select steers aux_i onto the pad per bit
  assign ext_pad_o   = (out_q & ~aux_q) | (aux_i & aux_q);
  assign ext_padoe_o = oe_q;

endmodule

/* source/gpio_input_sync.sv */
`timescale 1ns/10ps

module gpio_input_sync
  import gpio_pkg::*;
#(
  parameter int GPIO_W = DEF_GPIO_W
) (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic [GPIO_W-1:0] ext_pad_i,   // Asynchronous pads
  output logic [GPIO_W-1:0] pad_sync_o,
  output logic [GPIO_W-1:0] in_value_o
);

  logic [GPIO_W-1:0] meta_q;  // First stage, may go metastable

  // Two-flop synchronizer
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      meta_q     <= '0;
      pad_sync_o <= '0;
    end else begin
      meta_q     <= ext_pad_i;
      pad_sync_o <= meta_q;
    end
  end

  // Input register, previous sample for edge detect
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      in_value_o <= '0;
    end else begin
      in_value_o <= pad_sync_o;
    end
  end

endmodule

/* source/gpio_irq.sv */
`timescale 1ns/10ps

module gpio_irq
  import gpio_pkg::*;
#(
  parameter int GPIO_W = DEF_GPIO_W
) (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic              reg_wr_i,
  input  gpio_reg_e         reg_sel_i,
  input  logic [DATA_W-1:0] wb_dat_i,
  input  logic [GPIO_W-1:0] pad_sync_i,   // Current synchronized sample
  input  logic [GPIO_W-1:0] in_value_i,   // Previous sample
  input  logic [GPIO_W-1:0] ptrig_i,
  input  logic [GPIO_W-1:0] inte_i,
  input  logic              ctrl_inte_i,
  output logic [GPIO_W-1:0] ints_value_o,
  output logic              irq_pending_o,
  output logic              inta_o
);

  logic [GPIO_W-1:0] changed;
  logic [GPIO_W-1:0] edge_hit;

  assign changed = pad_sync_i ^ in_value_i;

  // New level must match the trigger polarity
  assign edge_hit = changed & ~(pad_sync_i ^ ptrig_i) & inte_i;

  // Status register
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ints_value_o <= '0;
    end else if (reg_wr_i && reg_sel_i == REG_INTS) begin
      ints_value_o <= wb_dat_i[GPIO_W-1:0];  // Write zeros to clear
    end else if (ctrl_inte_i) begin
      ints_value_o <= ints_value_o | edge_hit;
    end
  end

  assign irq_pending_o = ctrl_inte_i & (|ints_value_o);

  // Registered request line
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      inta_o <= 1'b0;
    end else begin
      inta_o <= irq_pending_o;
    end
  end

endmodule

/* source/gpio_top.sv */
`timescale 1ns/10ps

module gpio_top
  import gpio_pkg::*;
#(
  parameter int GPIO_W = DEF_GPIO_W,  // Number of pins, 1 to 32
  parameter int ADDR_W = DEF_ADDR_W   // 5 or more
) (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [DATA_W-1:0] wb_dat_i,
  input  logic [SEL_W-1:0]  wb_sel_i,
  output logic [DATA_W-1:0] wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  output logic              wb_inta_o,
  input  logic [GPIO_W-1:0] aux_i,
  input  logic [GPIO_W-1:0] ext_pad_i,
  output logic [GPIO_W-1:0] ext_pad_o,
  output logic [GPIO_W-1:0] ext_padoe_o
);

  logic              reg_wr;
  gpio_reg_e         reg_sel;
  logic [DATA_W-1:0] rd_data;
  logic [GPIO_W-1:0] pad_sync;
  logic [GPIO_W-1:0] in_value;
  logic [GPIO_W-1:0] ints_value;
  logic              irq_pending;
  logic [GPIO_W-1:0] ptrig;
  logic [GPIO_W-1:0] inte;
  logic              ctrl_inte;

  gpio_wb_slave #(.ADDR_W(ADDR_W)) u_wb_slave (
    .wb_clk_i (wb_clk_i),     .wb_rst_i  (wb_rst_i),
    .cyc_i    (wb_cyc_i),     .stb_i     (wb_stb_i),
    .we_i     (wb_we_i),      .adr_i     (wb_adr_i),
    .rd_data_i(rd_data),      .reg_wr_o  (reg_wr),
    .reg_sel_o(reg_sel),      .ack_o     (wb_ack_o),
    .err_o    (wb_err_o),     .dat_o     (wb_dat_o)
  );

  gpio_regs #(.GPIO_W(GPIO_W)) u_regs (
    .wb_clk_i     (wb_clk_i),     .wb_rst_i     (wb_rst_i),
    .reg_wr_i     (reg_wr),       .reg_sel_i    (reg_sel),
    .wb_dat_i     (wb_dat_i),     .wb_sel_i     (wb_sel_i),
    .in_value_i   (in_value),     .ints_value_i (ints_value),
    .irq_pending_i(irq_pending),  .aux_i        (aux_i),
    .rd_data_o    (rd_data),      .ptrig_o      (ptrig),
    .inte_o       (inte),         .ctrl_inte_o  (ctrl_inte),
    .ext_pad_o    (ext_pad_o),    .ext_padoe_o  (ext_padoe_o)
  );

  gpio_input_sync #(.GPIO_W(GPIO_W)) u_input_sync (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .ext_pad_i (ext_pad_i),
    .pad_sync_o(pad_sync),
    .in_value_o(in_value)
  );

  gpio_irq #(.GPIO_W(GPIO_W)) u_irq (
    .wb_clk_i     (wb_clk_i),     .wb_rst_i     (wb_rst_i),
    .reg_wr_i     (reg_wr),       .reg_sel_i    (reg_sel),
    .wb_dat_i     (wb_dat_i),     .pad_sync_i   (pad_sync),
    .in_value_i   (in_value),     .ptrig_i      (ptrig),
    .inte_i       (inte),         .ctrl_inte_i  (ctrl_inte),
    .ints_value_o (ints_value),   .irq_pending_o(irq_pending),
    .inta_o       (wb_inta_o)
  );

endmodule

/* sim/gpio_sva.sv */
`timescale 1ns/10ps

module gpio_sva (
  input logic wb_clk_i,
  input logic wb_rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic wb_err_o,
  input logic wb_inta_o
);

  int   fail_cnt = 0;  // Assertion failures so far
  logic term;

  assign term = wb_ack_o | wb_err_o;

  // Ack and err are exclusive
  ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o))
  else begin
    $error("ack and err high in the same cycle");
    fail_cnt++;
  end

  term_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    term |=> !term)
  else begin
    $error("termination lasted more than one cycle");
    fail_cnt++;
  end

  // Each termination answers the request of the cycle before
  term_after_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    term |-> $past(wb_cyc_i && wb_stb_i))
  else begin
    $error("ack or err without a request");
    fail_cnt++;
  end

  // First registered request value after reset release
  inta_after_reset: assert property (@(posedge wb_clk_i)
    $fell(wb_rst_i) |=> !wb_inta_o)
  else begin
    $error("interrupt line high right after reset");
    fail_cnt++;
  end

endmodule

bind gpio_top gpio_sva u_sva (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_o (wb_ack_o),
  .wb_err_o (wb_err_o),
  .wb_inta_o(wb_inta_o)
);

/* sim/tb_gpio.sv */
`timescale 1ns/10ps

module tb_gpio;

  localparam int TIMEOUT = 50;  // Cycles per wait loop
  localparam logic [7:0] ADR_OUT = 8'h04;
  localparam logic [7:0] ADR_AUX = 8'h14;
  localparam logic [7:0] ADR_CTRL = 8'h18;
  localparam logic [7:0] ADR_INTS = 8'h1c;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [7:0]  wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic        wb_inta_o;
  logic [31:0] aux_i;
  logic [31:0] ext_pad_i;
  logic [31:0] ext_pad_o;
  logic [31:0] ext_padoe_o;

  integer      seed;
  int          errors;
  int          checks;
  int          ntests;
  int          start_errs;
  int          total;
  string       test_name;
  logic [31:0] model [8];   // Expected register contents by word offset
  logic [31:0] rnd;
  logic [31:0] old_pad;
  logic [31:0] exp_ints;
  logic [31:0] rdat;
  logic [1:0]  resp;        // {err, ack}

  gpio_top #(.GPIO_W(32), .ADDR_W(8)) UUT (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .wb_inta_o(wb_inta_o),
    .aux_i(aux_i), .ext_pad_i(ext_pad_i), .ext_pad_o(ext_pad_o), .ext_padoe_o(ext_padoe_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else begin
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // One access entered and left 1 ns after a rising edge
  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rd,
                           output logic [1:0] rsp);
    int n;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    n = 0;
    rsp = 2'b00;
    while (rsp == 2'b00 && n < TIMEOUT) begin
      @(posedge wb_clk_i);
      #1;
      rsp = {wb_err_o, wb_ack_o};
      n++;
    end
    rd = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (rsp == 2'b00) begin
      $display("timeout: no ack or err for the access at address %h", adr);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    bus_cycle(1'b1, adr, dat, sel, rdat, resp);
    check_eq($sformatf("write response at %h", adr), 32'h1, {30'b0, resp});
  endtask

  task automatic read_reg(input logic [7:0] adr, input logic [31:0] exp);
    bus_cycle(1'b0, adr, 32'h0, 4'h0, rdat, resp);
    check_eq($sformatf("read response at %h", adr), 32'h1, {30'b0, resp});
    check_eq($sformatf("read data at %h", adr), exp, rdat);
  endtask

  task automatic wait_inta(input logic level);
    int n;
    n = 0;
    while (wb_inta_o !== level && n < TIMEOUT) begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end
    if (wb_inta_o !== level) begin
      $display("timeout: interrupt line never went to %b", level);
      errors++;
    end
    check_eq("inta", {31'b0, level}, {31'b0, wb_inta_o});
  endtask

  // Aux select picks aux_i over the output register per pin
  function automatic logic [31:0] pad_model();
    logic [31:0] p;
    for (int i = 0; i < 32; i++) begin
      p[i] = model[5][i] ? aux_i[i] : model[1][i];
    end
    return p;
  endfunction

  // Enabled pins rising with PTRIG 1 or falling with PTRIG 0
  function automatic logic [31:0] edge_model(input logic [31:0] was, input logic [31:0] now);
    return ((~was & now & model[4]) | (was & ~now & ~model[4])) & model[3];
  endfunction

  task automatic model_write(input int ofs, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] m;
    m = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    model[ofs] = (model[ofs] & ~m) | (dat & m);
    write_reg(8'(ofs * 4), dat, sel);
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    start_errs = errors;
  endtask

  task automatic end_test();
    ntests++;
    $display("test %s done, %0d errors", test_name, errors - start_errs);
  endtask

  initial begin
    int ofs;
    wb_rst_i  = 1'b1;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    aux_i     = '0;
    ext_pad_i = '0;
    seed      = 32'h7899_0651;
    errors    = 0;
    checks    = 0;
    ntests    = 0;
    for (int i = 0; i < 8; i++) begin
      model[i] = '0;
    end
    repeat (8) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;

    begin_test("reset");
    for (int i = 0; i < 8; i++) begin
      read_reg(8'(i * 4), 32'h0);
    end
    check_eq("ext_pad_o", 32'h0, ext_pad_o);
    check_eq("ext_padoe_o", 32'h0, ext_padoe_o);
    end_test();

    begin_test("lanes");
    for (int k = 0; k < 24; k++) begin
      rnd = $random(seed);
      ofs = 1 + int'(rnd[7:0] % 8'd5);   // OUT to AUX
      rnd = $random(seed);
      model_write(ofs, $random(seed), rnd[3:0]);
      read_reg(8'(ofs * 4), model[ofs]);
      check_eq("ext_pad_o", pad_model(), ext_pad_o);
      check_eq("ext_padoe_o", model[2], ext_padoe_o);
    end
    end_test();

    begin_test("aux");
    model_write(5, 32'h0000_ffff, 4'hf);
    model_write(1, $random(seed), 4'hf);
    for (int k = 0; k < 6; k++) begin
      aux_i = $random(seed);
      @(posedge wb_clk_i);
      #1;
      check_eq("ext_pad_o", pad_model(), ext_pad_o);
    end
    end_test();

    begin_test("input");
    for (int k = 0; k < 4; k++) begin
      ext_pad_i = $random(seed);
      repeat (3) @(posedge wb_clk_i);  // Two sync flops and the input register
      #1;
      read_reg(8'h00, ext_pad_i);
    end
    end_test();

    begin_test("irq");
    ext_pad_i = 32'h0000_00f8;
    repeat (3) @(posedge wb_clk_i);
    #1;
    model_write(7, 32'h0, 4'hf);
    model_write(3, 32'h0000_00ff, 4'hf);
    model_write(4, 32'h0000_000f, 4'hf);   // Bits 0 to 3 rising and 4 to 7 falling
    write_reg(ADR_CTRL, 32'h1, 4'hf);
    old_pad = ext_pad_i;
    ext_pad_i = old_pad | 32'h0000_0202;   // Bit 9 is not enabled
    exp_ints = edge_model(old_pad, ext_pad_i);
    wait_inta(1'b1);
    read_reg(ADR_INTS, exp_ints);
    read_reg(ADR_CTRL, 32'h3);
    old_pad = ext_pad_i;
    ext_pad_i = old_pad & ~32'h0000_0048;  // Bit 3 falls against its polarity
    exp_ints = exp_ints | edge_model(old_pad, ext_pad_i);
    repeat (3) @(posedge wb_clk_i);
    #1;
    read_reg(ADR_INTS, exp_ints);
    write_reg(ADR_INTS, 32'h0, 4'hf);
    write_reg(ADR_CTRL, 32'h1, 4'hf);
    wait_inta(1'b0);
    read_reg(ADR_CTRL, 32'h1);
    read_reg(ADR_INTS, 32'h0);
    end_test();

    begin_test("errors");
    bus_cycle(1'b1, ADR_OUT | 8'h01, ~model[1], 4'hf, rdat, resp);
    check_eq("response bit 0 write", 32'h2, {30'b0, resp});
    bus_cycle(1'b1, ADR_OUT | 8'h80, ~model[1], 4'hf, rdat, resp);
    check_eq("response upper bit write", 32'h2, {30'b0, resp});
    bus_cycle(1'b0, ADR_AUX | 8'h02, 32'h0, 4'h0, rdat, resp);
    check_eq("response bit 1 read", 32'h2, {30'b0, resp});
    read_reg(ADR_OUT, model[1]);
    read_reg(ADR_AUX, model[5]);
    check_eq("ext_pad_o", pad_model(), ext_pad_o);
    end_test();

    total = errors + UUT.u_sva.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors", ntests, checks, total);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* sim.f */
source/gpio_pkg.sv
source/gpio_wb_slave.sv
source/gpio_regs.sv
source/gpio_input_sync.sv
source/gpio_irq.sv
source/gpio_top.sv
sim/gpio_sva.sv
sim/tb_gpio.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the GPIO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_gpio -f sim.f -o tb_gpio_sim

# Raised error limit so assertion failures reach the summary
out=$(./obj_dir/tb_gpio_sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED"
  exit 1
fi
